// File: verilog.f
+incdir+logic
logic/loader_pkg.sv
logic/media_pkg.sv
logic/dl_classify.sv
logic/ram_download_writer.sv
logic/media_tracker.sv
logic/psx_loader_top.sv
bench/psx_loader_properties.sv
bench/tb_psx_loader.sv

// File: Bender.yml
package:
  name: psx_loader

export_include_dirs:
  - logic

sources:
  - logic/loader_pkg.sv
  - logic/media_pkg.sv
  - logic/dl_classify.sv
  - logic/ram_download_writer.sv
  - logic/media_tracker.sv
  - logic/psx_loader_top.sv
  - target: test
    files:
      - bench/psx_loader_properties.sv
      - bench/tb_psx_loader.sv

// File: bench/tb_psx_loader.sv
/* Testbench for the loader top level. Runs core passthrough, BIOS and EXE
   downloads and media events; the bound properties do most of the checking. */

`timescale 1ns/1ps
`include "loader_consts.svh"

module tb_psx_loader;
	import loader_pkg::*;
	import media_pkg::*;

	localparam int CLK_PERIOD      = 10;
	localparam int BIOS_PAIRS      = 12;
	localparam int EXE_PAIRS       = 8;
	localparam int WATCHDOG_CYCLES = 8 * 2 * (BIOS_PAIRS + EXE_PAIRS) + 2000;

	logic          clk_1x;
	logic          rst_n;
	logic          dl_active;
	logic [7:0]    dl_index;
	host_beat_t    beat;
	ram_wr_t       core_wr;
	logic          ram_ack = 1'b0;
	mount_evt_t    mount;
	logic          osd_load;
	logic          osd_save;
	logic          osd_open;
	logic          autosave;
	dl_kind_e      dl_kind;
	logic          exe_load;
	ram_wr_t       ram_wr;
	logic          ioctl_wait;
	media_status_t media;
	card_cmd_t     card_cmd;

	ram_wr_t       expected[$];
	int            writes_seen = 0;
	int            exe_pulses = 0;
	integer        seed = 32'h3381;
	integer        ack_seed = 32'h3381;
	logic [2:0]    ack_wait = 3'd0;
	logic [2:0]    ack_lat;
	logic [31:0]   r0;
	logic [31:0]   r1;
	logic [63:0]   cd_img;

	psx_loader_top uut (.*);

	bind psx_loader_top psx_loader_properties props (.*);

	initial begin
		clk_1x = 1'b0;
		forever #(CLK_PERIOD / 2) clk_1x = ~clk_1x;
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic compare_value(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		if (got !== exp)
			stop_with_failure($sformatf("FAIL %s expected 0x%h got 0x%h", name, exp, got));
	endtask

	// Low half first, then the high half at the next half-word address
	task automatic send_pair(input logic [26:0] addr, input logic [31:0] word,
			input logic [26:0] base);
		@(posedge clk_1x);
		while (ioctl_wait)
			@(posedge clk_1x);
		expected.push_back(ram_wr_t'{req: 1'b1, addr: addr + base, data: word, be: 4'hF});
		beat <= '{wr: 1'b1, addr: addr, data: word[15:0]};
		@(posedge clk_1x);
		beat <= '{wr: 1'b1, addr: addr | 27'd2, data: word[31:16]};
		@(posedge clk_1x);
		beat <= '0;
	endtask

	task automatic run_download(input logic [7:0] idx, input logic [26:0] base,
			input int pairs);
		logic [31:0] r_addr;
		logic [31:0] r_word;
		@(posedge clk_1x);
		dl_active <= 1'b1;
		dl_index  <= idx;
		repeat (2) @(posedge clk_1x);
		for (int i = 0; i < pairs; i++) begin
			r_addr = $random(seed);
			r_word = $random(seed);
			send_pair({r_addr[26:2], 2'b00}, r_word, base);
		end
		@(posedge clk_1x);
		while (ioctl_wait)
			@(posedge clk_1x);
		dl_active <= 1'b0;
		repeat (4) @(posedge clk_1x);
	endtask

	task automatic mount_image(input logic [2:0] slots, input logic [63:0] size);
		@(posedge clk_1x);
		mount <= '{cd: slots[2], mc1: slots[1], mc2: slots[0], size: size};
		@(posedge clk_1x);
		mount <= '0;
	endtask

	// ========================================
	// RAM acknowledge model and write checker
	// ========================================
	always @(posedge clk_1x) begin
		if (!rst_n) begin
			ram_ack  <= 1'b0;
			ack_wait <= 3'd0;
		end else if (ack_wait != 3'd0) begin
			ram_ack  <= (ack_wait == 3'd1);
			ack_wait <= ack_wait - 3'd1;
		end else if (ram_wr.req && dl_kind != DL_NONE) begin
			ack_lat = 3'd1 + 3'({$random(ack_seed)} % 4);
			ram_ack  <= (ack_lat == 3'd1);
			ack_wait <= ack_lat - 3'd1;
		end else begin
			ram_ack <= 1'b0;
		end
	end

	always @(posedge clk_1x) begin
		if (rst_n && uut.props.fail_count != 0)
			stop_with_failure("A concurrent assertion failed during the run");
		if (rst_n && exe_load)
			exe_pulses++;
		if (rst_n && dl_kind != DL_NONE && ram_wr.req) begin
			writes_seen++;
			if (expected.size() == 0)
				stop_with_failure("Download write appeared with no expected value");
			compare_value("ram_wr.addr", expected[0].addr, ram_wr.addr);
			compare_value("ram_wr.data", expected[0].data, ram_wr.data);
			compare_value("ram_wr.be", expected[0].be, ram_wr.be);
			void'(expected.pop_front());
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		stop_with_failure("Timeout: the run did not finish in time");
	end

	initial begin
		rst_n     <= 1'b0;
		dl_active <= 1'b0;
		dl_index  <= 8'd0;
		beat      <= '0;
		core_wr   <= '0;
		mount     <= '0;
		osd_load  <= 1'b0;
		osd_save  <= 1'b0;
		osd_open  <= 1'b0;
		autosave  <= 1'b0;
		repeat (16) @(posedge clk_1x);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk_1x);

		// Random core writes outside any download
		for (int i = 0; i < 64; i++) begin
			@(posedge clk_1x);
			r0 = $random(seed);
			r1 = $random(seed);
			core_wr <= '{req: r0[31], addr: r0[26:0], data: r1, be: r0[30:27]};
		end
		@(posedge clk_1x);
		core_wr <= '0;

		run_download(`IDX_BIOS, 27'(`BIOS_START), BIOS_PAIRS);
		run_download(`IDX_EXE, 27'(`EXE_START), EXE_PAIRS);

		// Unknown index leaves the core on the write channel
		@(posedge clk_1x);
		dl_active <= 1'b1;
		dl_index  <= 8'h07;
		repeat (4) @(posedge clk_1x);
		dl_active <= 1'b0;
		repeat (4) @(posedge clk_1x);

		// CD insert then eject, then both cards in and card 1 out
		cd_img = {$random(seed), $random(seed)} | 64'h1;
		mount_image(3'b100, cd_img);
		mount_image(3'b100, 64'd0);
		@(posedge clk_1x);
		compare_value("media.cd_size", cd_img[`CD_SIZE_W-1:0], media.cd_size);
		mount_image(3'b010, 64'h2_0000);
		mount_image(3'b001, 64'h2_0000);
		mount_image(3'b010, 64'd0);

		// On-screen controls
		@(posedge clk_1x);
		osd_load <= 1'b1;
		repeat (3) @(posedge clk_1x);
		osd_load <= 1'b0;
		osd_save <= 1'b1;
		repeat (3) @(posedge clk_1x);
		osd_save <= 1'b0;
		osd_open <= 1'b1;
		repeat (3) @(posedge clk_1x);
		autosave <= 1'b1;
		repeat (3) @(posedge clk_1x);
		osd_open <= 1'b0;
		autosave <= 1'b0;
		repeat (4) @(posedge clk_1x);

		compare_value("ram_wr.req count", BIOS_PAIRS + EXE_PAIRS, writes_seen);
		compare_value("exe_load pulse count", 1, exe_pulses);
		if (uut.props.fail_count != 0) begin
			stop_with_failure("A concurrent assertion failed during the run");
		end else begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

// File: bench/psx_loader_properties.sv
/* Concurrent assertions on the loader top level: reset values, download
   timing, core passthrough and media events. Bound to psx_loader_top. */

`timescale 1ns/1ps
`include "loader_consts.svh"

module psx_loader_properties (
	input logic                     clk_1x,
	input logic                     rst_n,
	input logic                     dl_active,
	input logic [7:0]               dl_index,
	input loader_pkg::ram_wr_t      core_wr,
	input logic                     ram_ack,
	input media_pkg::mount_evt_t    mount,
	input logic                     osd_load,
	input logic                     osd_save,
	input logic                     osd_open,
	input logic                     autosave,
	input loader_pkg::dl_kind_e     dl_kind,
	input logic                     exe_load,
	input loader_pkg::ram_wr_t      ram_wr,
	input logic                     ioctl_wait,
	input media_pkg::media_status_t media,
	input media_pkg::card_cmd_t     card_cmd
);
	import loader_pkg::*;
	import media_pkg::*;

	int unsigned fail_count = 0;

	task automatic flag_failure(input string what);
		$error("%s", what);
		fail_count++;
	endtask

	assert property (@(posedge clk_1x) !rst_n |=> !ram_wr.req && !ioctl_wait && !exe_load
		&& card_cmd == '0 && media == '0 && dl_kind == DL_NONE)
		else flag_failure("Outputs not at their reset values");

	// ========================================
	// Download path
	// ========================================
	// Kind follows the host index one cycle later
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		dl_kind == (!$past(dl_active) ? DL_NONE
			: ($past(dl_index) == `IDX_BIOS) ? DL_BIOS
			: ($past(dl_index) == `IDX_EXE) ? DL_EXE : DL_NONE))
		else flag_failure("dl_kind does not follow the download index");
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		$fell(dl_active) && dl_kind == DL_EXE |-> ##2 exe_load ##1 !exe_load)
		else flag_failure("exe_load missing or not one cycle wide after EXE download");
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		exe_load |-> $past(dl_kind == DL_EXE, 2) && !$past(dl_active, 2))
		else flag_failure("exe_load without a finished EXE download");
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		$rose(ioctl_wait) == (ram_wr.req && dl_kind != DL_NONE))
		else flag_failure("ioctl_wait did not rise together with the download write");
	// Held until the cycle after the acknowledge, then released
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		ioctl_wait |=> ioctl_wait == !$past(ram_ack))
		else flag_failure("ioctl_wait did not follow the RAM acknowledge");
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		dl_kind == DL_NONE |-> ram_wr == core_wr && !ioctl_wait)
		else flag_failure("Core write not passed through outside a download");

	// ========================================
	// Media status and card commands
	// ========================================
	assert property (@(posedge clk_1x) disable iff (!rst_n) mount.cd && mount.size != 0
		|=> media.has_cd && media.cd_size == $past(mount.size[`CD_SIZE_W-1:0]))
		else flag_failure("CD mount did not set has_cd and cd_size");
	assert property (@(posedge clk_1x) disable iff (!rst_n) mount.cd && mount.size == 0
		|=> !media.has_cd && media.cd_size == $past(media.cd_size))
		else flag_failure("CD eject did not clear has_cd or lost cd_size");
	assert property (@(posedge clk_1x) disable iff (!rst_n) mount.mc1
		|=> media.mc1_available == $past(mount.size != 0)
		&& card_cmd.load1 == $past(mount.size != 0))
		else flag_failure("Card 1 mount gave wrong availability or load");
	assert property (@(posedge clk_1x) disable iff (!rst_n) mount.mc2
		|=> media.mc2_available == $past(mount.size != 0)
		&& card_cmd.load2 == $past(mount.size != 0))
		else flag_failure("Card 2 mount gave wrong availability or load");
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		$rose(osd_load) |=> card_cmd.load1 && card_cmd.load2)
		else flag_failure("Load control edge did not pulse both card loads");
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		!(mount.mc1 && mount.size != 0) && !$rose(osd_load) |=> !card_cmd.load1)
		else flag_failure("Card 1 load pulse without a cause");
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		!(mount.mc2 && mount.size != 0) && !$rose(osd_load) |=> !card_cmd.load2)
		else flag_failure("Card 2 load pulse without a cause");
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		$rose(osd_save) || $rose(osd_open && autosave) |=> card_cmd.save)
		else flag_failure("Save or autosave edge did not pulse save");
	assert property (@(posedge clk_1x) disable iff (!rst_n)
		!$rose(osd_save) && !$rose(osd_open && autosave) |=> !card_cmd.save)
		else flag_failure("Save pulse without a cause");

endmodule

// File: logic/psx_loader_top.sv
/* Top level of the loader: download classifier and RAM writer in series,
   media tracking alongside. Instances and wires only. */

`timescale 1ns/1ps

module psx_loader_top (
	input  logic                     clk_1x,
	input  logic                     rst_n,
	// Host download
	input  logic                     dl_active,
	input  logic [7:0]               dl_index,
	input  loader_pkg::host_beat_t   beat,
	// RAM write channel
	input  loader_pkg::ram_wr_t      core_wr,
	input  logic                     ram_ack,
	// Media controls
	input  media_pkg::mount_evt_t    mount,
	input  logic                     osd_load,
	input  logic                     osd_save,
	input  logic                     osd_open,
	input  logic                     autosave,
	output loader_pkg::dl_kind_e     dl_kind,
	output logic                     exe_load,
	output loader_pkg::ram_wr_t      ram_wr,
	output logic                     ioctl_wait,
	output media_pkg::media_status_t media,
	output media_pkg::card_cmd_t     card_cmd
);

	dl_classify u_classify (
		.clk_1x    (clk_1x),
		.rst_n     (rst_n),
		.dl_active (dl_active),
		.dl_index  (dl_index),
		.kind      (dl_kind),
		.exe_load  (exe_load)
	);

	ram_download_writer u_writer (
		.clk_1x     (clk_1x),
		.rst_n      (rst_n),
		.kind       (dl_kind),
		.beat       (beat),
		.core_wr    (core_wr),
		.ram_ack    (ram_ack),
		.ram_wr     (ram_wr),
		.ioctl_wait (ioctl_wait)
	);

	// Not in series with the download path
	media_tracker u_media (
		.clk_1x   (clk_1x),
		.rst_n    (rst_n),
		.mount    (mount),
		.osd_load (osd_load),
		.osd_save (osd_save),
		.osd_open (osd_open),
		.autosave (autosave),
		.media    (media),
		.card_cmd (card_cmd)
	);

endmodule

// File: logic/media_tracker.sv
/* Keeps CD and memory-card mount status and turns the on-screen load,
   save and autosave controls into single-cycle card commands. */

`timescale 1ns/1ps
`include "loader_consts.svh"

module media_tracker (
	input  logic                     clk_1x,
	input  logic                     rst_n,
	input  media_pkg::mount_evt_t    mount,
	input  logic                     osd_load,
	input  logic                     osd_save,
	input  logic                     osd_open,
	input  logic                     autosave,
	output media_pkg::media_status_t media,
	output media_pkg::card_cmd_t     card_cmd
);
	import media_pkg::*;

	logic      size_nz;
	logic      save_auto;
	logic      old_load;
	logic      old_save;
	logic      old_save_auto;
	card_cmd_t cmd_next;

	assign size_nz   = |mount.size;
	assign save_auto = osd_open & autosave;

	// ========================================
	// Card command decode
	// ========================================
	always_comb begin
		cmd_next.load1 = mount.mc1 && size_nz;
		cmd_next.load2 = mount.mc2 && size_nz;
		if (osd_load && !old_load) begin
			cmd_next.load1 = 1'b1;
			cmd_next.load2 = 1'b1;
		end
		// Manual save or autosave when the menu opens
		cmd_next.save = (osd_save && !old_save) || (save_auto && !old_save_auto);
	end

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			card_cmd      <= '0;
			old_load      <= 1'b0;
			old_save      <= 1'b0;
			old_save_auto <= 1'b0;
		end else begin
			card_cmd      <= cmd_next;
			old_load      <= osd_load;
			old_save      <= osd_save;
			old_save_auto <= save_auto;
		end
	end

	// ========================================
	// Mount status
	// ========================================
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			media <= '0;
		end else begin
			if (mount.cd) begin
				// Empty image ejects but the old size stays
				media.has_cd <= size_nz;
				if (size_nz)
					media.cd_size <= mount.size[`CD_SIZE_W-1:0];
			end
			if (mount.mc1)
				media.mc1_available <= size_nz;
			if (mount.mc2)
				media.mc2_available <= size_nz;
		end
	end

endmodule

// File: logic/ram_download_writer.sv
/* Packs pairs of 16-bit host beats into 32-bit RAM writes, holds the host
   off until each write is acknowledged, and picks the RAM write source. */

`timescale 1ns/1ps
`include "loader_consts.svh"

module ram_download_writer (
	input  logic                   clk_1x,
	input  logic                   rst_n,
	input  loader_pkg::dl_kind_e   kind,
	input  loader_pkg::host_beat_t beat,
	input  loader_pkg::ram_wr_t    core_wr,
	input  logic                   ram_ack,
	output loader_pkg::ram_wr_t    ram_wr,
	output logic                   ioctl_wait
);
	import loader_pkg::*;

	localparam logic [`RAM_ADDR_W-1:0] BIOS_BASE = `RAM_ADDR_W'(`BIOS_START);
	localparam logic [`RAM_ADDR_W-1:0] EXE_BASE  = `RAM_ADDR_W'(`EXE_START);

	typedef enum logic [1:0] {
		W_LOW,
		W_HIGH,
		W_WAIT
	} phase_e;

	phase_e                 phase;
	logic                   dl_req;
	logic [`RAM_ADDR_W-1:0] wr_addr;
	logic [31:0]            wr_data;
	logic [`RAM_ADDR_W-1:0] base;
	ram_wr_t                dl_wr;

	assign base = (kind == DL_EXE) ? EXE_BASE : BIOS_BASE;

	// ========================================
	// Beat packing and ack wait
	// ========================================
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			phase  <= W_LOW;
			dl_req <= 1'b0;
		end else begin
			dl_req <= 1'b0;
			if (kind == DL_NONE) begin
				phase <= W_LOW;
			end else if (phase == W_WAIT) begin
				if (ram_ack)
					phase <= W_LOW;
			end else if (beat.wr) begin
				// Bit 1 of the byte address selects the half word
				if (!beat.addr[1]) begin
					phase <= W_HIGH;
				end else if (phase == W_HIGH) begin
					// Request only once the low half is in
					dl_req <= 1'b1;
					phase  <= W_WAIT;
				end
			end
		end
	end

	// Assembled word and target address
	always_ff @(posedge clk_1x) begin
		if (beat.wr && phase != W_WAIT) begin
			if (!beat.addr[1]) begin
				wr_data[15:0] <= beat.data;
				wr_addr       <= beat.addr + base;
			end else begin
				wr_data[31:16] <= beat.data;
			end
		end
	end

	assign dl_wr = '{req: dl_req, addr: wr_addr, data: wr_data, be: 4'hF};

	// Core owns the write channel outside downloads
	assign ram_wr     = (kind == DL_NONE) ? core_wr : dl_wr;
	assign ioctl_wait = (phase == W_WAIT) && (kind != DL_NONE);

endmodule

// File: logic/dl_classify.sv
/* Registers the download kind from the host index and gives the
   one-cycle EXE-load pulse once an EXE download has finished. */

`timescale 1ns/1ps
`include "loader_consts.svh"

module dl_classify (
	input  logic                 clk_1x,
	input  logic                 rst_n,
	input  logic                 dl_active,
	input  logic [7:0]           dl_index,
	output loader_pkg::dl_kind_e kind,
	output logic                 exe_load
);
	import loader_pkg::*;

	dl_kind_e kind_next;
	logic     exe_q;

	// Unknown indices decode to DL_NONE
	always_comb begin
		kind_next = DL_NONE;
		if (dl_active) begin
			case (dl_index)
				`IDX_BIOS: kind_next = DL_BIOS;
				`IDX_EXE:  kind_next = DL_EXE;
				default:   kind_next = DL_NONE;
			endcase
		end
	end

	// ========================================
	// Kind register and EXE end detect
	// ========================================
	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			kind     <= DL_NONE;
			exe_q    <= 1'b0;
			exe_load <= 1'b0;
		end else begin
			kind     <= kind_next;
			exe_q    <= (kind == DL_EXE);
			// Falling edge of the registered EXE flag
			exe_load <= exe_q && (kind != DL_EXE);
		end
	end

endmodule

// File: logic/media_pkg.sv
/* Types for CD and memory-card mounts, the resulting media status
   and the card load and save commands. */

`include "loader_consts.svh"

package media_pkg;

	// Mount strobes from the host, one per slot
	typedef struct packed {
		logic                   cd;
		logic                   mc1;
		logic                   mc2;
		logic [`IMG_SIZE_W-1:0] size;
	} mount_evt_t;

	typedef struct packed {
		logic                  has_cd;
		logic [`CD_SIZE_W-1:0] cd_size;
		logic                  mc1_available;
		logic                  mc2_available;
	} media_status_t;

	// Single-cycle card commands
	typedef struct packed {
		logic load1;
		logic load2;
		logic save;
	} card_cmd_t;

endpackage

// File: logic/loader_pkg.sv
/* Types for the host download path and the RAM write channel.
   Shared by the classifier, the RAM writer and the top level. */

`include "loader_consts.svh"

package loader_pkg;

	// Kind of download currently in progress
	typedef enum logic [1:0] {
		DL_NONE = 2'd0,
		DL_BIOS = 2'd1,
		DL_EXE  = 2'd2
	} dl_kind_e;

	// One 16-bit host beat, byte addressed
	typedef struct packed {
		logic                   wr;
		logic [`RAM_ADDR_W-1:0] addr;
		logic [15:0]            data;
	} host_beat_t;

	// One request on the RAM write channel
	typedef struct packed {
		logic                   req;
		logic [`RAM_ADDR_W-1:0] addr;
		logic [31:0]            data;
		logic [3:0]             be;
	} ram_wr_t;

endpackage

// File: logic/loader_consts.svh
/* Fixed constants for the download loader and media bookkeeping.
   Included by the packages and by any module that needs a base address. */

`ifndef LOADER_CONSTS_SVH
`define LOADER_CONSTS_SVH

// RAM byte bases for the two download kinds
`define BIOS_START 32'h0020_0000
`define EXE_START  32'h0040_0000

// Host download index values
`define IDX_BIOS 8'd0
`define IDX_EXE  8'd1

// Field widths
`define RAM_ADDR_W 27
`define CD_SIZE_W  30
`define IMG_SIZE_W 64

`endif
